//--- heep_ext_subsys.f
source/heep_ext_pkg.sv
source/reg_bus_ctrl.sv
source/switch_ack_delay.sv
source/gpio_cnt.sv
source/intr_regs.sv
source/heep_ext_subsys.sv
test/tb_clk_gen.sv
test/tb_checker.sv
test/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_top \
  -f heep_ext_subsys.f \
  --Mdir build -o tb_top_sim

status=0
if ! ./build/tb_top_sim > sim.log 2>&1; then
  status=1
fi
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  exit 1
fi
exit $status

//--- source/gpio_cnt.sv
// GPIO high-cycle counter with CTRL, LIMIT and COUNT registers.
// Toggles gpio_o and pulses wrap_o each time the count hits the limit.
module gpio_cnt (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  heep_ext_pkg::reg_req_t reg_req_i,
  output heep_ext_pkg::reg_rsp_t reg_rsp_o,
  input  logic                   gpio_i,
  output logic                   gpio_o,
  output logic                   wrap_o
);
  import heep_ext_pkg::*;

  logic             enable_q;
  logic [CNT_W-1:0] limit_q;
  logic [CNT_W-1:0] count_q;
  logic             gpio_q;
  logic             wrap_q;
  logic             wr_ctrl;
  logic             wr_limit;

  assign wr_ctrl  = reg_req_i.valid & reg_req_i.write & (reg_req_i.addr == REG_CTRL);
  assign wr_limit = reg_req_i.valid & reg_req_i.write & (reg_req_i.addr == REG_LIMIT);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q <= 1'b0;
      limit_q  <= '0;
    end else begin
      if (wr_ctrl) begin
        enable_q <= reg_req_i.wdata[0];
      end
      if (wr_limit) begin
        limit_q <= reg_req_i.wdata[CNT_W-1:0];
      end
    end
  end

  // Counts only on enabled cycles with the pin high
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
      gpio_q  <= 1'b0;
      wrap_q  <= 1'b0;
    end else begin
      wrap_q <= 1'b0;
      if (enable_q && gpio_i) begin
        if (count_q == limit_q) begin
          count_q <= '0;
          gpio_q  <= ~gpio_q;
          wrap_q  <= 1'b1;
        end else begin
          count_q <= count_q + CNT_W'(1);
        end
      end
    end
  end

  assign gpio_o = gpio_q;
  assign wrap_o = wrap_q;

  // Same-cycle read, COUNT is read-only
  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.addr)
      REG_CTRL:  reg_rsp_o.rdata = DATA_W'(enable_q);
      REG_LIMIT: reg_rsp_o.rdata = DATA_W'(limit_q);
      REG_COUNT: reg_rsp_o.rdata = DATA_W'(count_q);
      default:   reg_rsp_o.rdata = '0;
    endcase
  end

endmodule

//--- source/heep_ext_pkg.sv
// Shared types and constants for the external subsystem.
// Register bus structs, power-switch bundle, address map and sizes.
package heep_ext_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Register bus slots
  localparam int unsigned NUM_SLOTS     = 2;
  localparam int unsigned SLOT_GPIO_CNT = 0;
  localparam int unsigned SLOT_INTR     = 1;

  localparam logic [NUM_SLOTS-1:0][ADDR_W-1:0] SLOT_BASE = {
    32'h2000_0100,
    32'h2000_0000
  };
  localparam logic [ADDR_W-1:0] SLOT_SPAN = 32'h0000_0100;

  // Power domains
  localparam int unsigned NUM_BANKS          = 4;
  localparam int unsigned EXT_DOMAINS        = 2;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;

  localparam int unsigned NEXT_INT = 8;
  localparam int unsigned CNT_W    = 16;

  // GPIO counter offsets
  localparam logic [ADDR_W-1:0] REG_CTRL  = 32'h0;
  localparam logic [ADDR_W-1:0] REG_LIMIT = 32'h4;
  localparam logic [ADDR_W-1:0] REG_COUNT = 32'h8;

  // Interrupt block offsets
  localparam logic [ADDR_W-1:0] REG_PENDING = 32'h0;
  localparam logic [ADDR_W-1:0] REG_ENABLE  = 32'h4;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [ADDR_W-1:0]     addr;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W/8-1:0]   wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              error;
    logic              ready;
  } reg_rsp_t;

  typedef logic [NUM_BANKS-1:0]   bank_vec_t;
  typedef logic [EXT_DOMAINS-1:0] ext_dom_vec_t;

  // Active-low switch requests, also reused for the acknowledges
  typedef struct packed {
    logic         cpu_n;
    logic         periph_n;
    bank_vec_t    banks_n;
    ext_dom_vec_t ext_n;
  } pwr_switch_t;

  typedef logic [NEXT_INT-1:0] intr_vec_t;

endpackage

//--- source/heep_ext_subsys.sv
// External subsystem top: register bus demux, switch-cell delay lines,
// GPIO counter and interrupt block.
module heep_ext_subsys (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  heep_ext_pkg::reg_req_t                reg_req_i,
  output heep_ext_pkg::reg_rsp_t                reg_rsp_o,
  input  heep_ext_pkg::pwr_switch_t             switch_n_i,
  output heep_ext_pkg::pwr_switch_t             switch_ack_n_o,
  input  logic                                  gpio_i,
  output logic                                  gpio_o,
  input  logic [heep_ext_pkg::NEXT_INT-2:0]     intr_ext_i,
  output logic                                  irq_o
);
  import heep_ext_pkg::*;

  reg_req_t [NUM_SLOTS-1:0] slot_req;
  reg_rsp_t [NUM_SLOTS-1:0] slot_rsp;
  logic                     cnt_wrap;
  intr_vec_t                intr_vec;

  // Line 0 is the counter wrap, the rest come from outside
  assign intr_vec = {intr_ext_i, cnt_wrap};

  reg_bus_ctrl reg_bus_ctrl_i (
    .reg_req_i (reg_req_i),
    .reg_rsp_o (reg_rsp_o),
    .slot_req_o(slot_req),
    .slot_rsp_i(slot_rsp)
  );

  // Stand-ins for the power-switch cells
  switch_ack_delay #(
    .payload_t(logic),
    .LATENCY  (SWITCH_ACK_LATENCY)
  ) cpu_ack_dly_i (
    .clk_i,
    .arst_n_i,
    .switch_n_i    (switch_n_i.cpu_n),
    .switch_ack_n_o(switch_ack_n_o.cpu_n)
  );

  switch_ack_delay #(
    .payload_t(logic),
    .LATENCY  (SWITCH_ACK_LATENCY)
  ) periph_ack_dly_i (
    .clk_i,
    .arst_n_i,
    .switch_n_i    (switch_n_i.periph_n),
    .switch_ack_n_o(switch_ack_n_o.periph_n)
  );

  switch_ack_delay #(
    .payload_t(bank_vec_t),
    .LATENCY  (SWITCH_ACK_LATENCY)
  ) banks_ack_dly_i (
    .clk_i,
    .arst_n_i,
    .switch_n_i    (switch_n_i.banks_n),
    .switch_ack_n_o(switch_ack_n_o.banks_n)
  );

  switch_ack_delay #(
    .payload_t(ext_dom_vec_t),
    .LATENCY  (SWITCH_ACK_LATENCY)
  ) ext_ack_dly_i (
    .clk_i,
    .arst_n_i,
    .switch_n_i    (switch_n_i.ext_n),
    .switch_ack_n_o(switch_ack_n_o.ext_n)
  );

  gpio_cnt gpio_cnt_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i(slot_req[SLOT_GPIO_CNT]),
    .reg_rsp_o(slot_rsp[SLOT_GPIO_CNT]),
    .gpio_i,
    .gpio_o,
    .wrap_o   (cnt_wrap)
  );

  intr_regs intr_regs_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i(slot_req[SLOT_INTR]),
    .reg_rsp_o(slot_rsp[SLOT_INTR]),
    .intr_i   (intr_vec),
    .irq_o
  );

endmodule

//--- source/intr_regs.sv
// Sticky interrupt pending and enable registers.
// Drives one combined interrupt request line.
module intr_regs (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  heep_ext_pkg::reg_req_t  reg_req_i,
  output heep_ext_pkg::reg_rsp_t  reg_rsp_o,
  input  heep_ext_pkg::intr_vec_t intr_i,
  output logic                    irq_o
);
  import heep_ext_pkg::*;

  intr_vec_t pending_q;
  intr_vec_t enable_q;
  intr_vec_t clr_mask;
  logic      wr_pending;
  logic      wr_enable;

  assign wr_pending = reg_req_i.valid & reg_req_i.write & (reg_req_i.addr == REG_PENDING);
  assign wr_enable  = reg_req_i.valid & reg_req_i.write & (reg_req_i.addr == REG_ENABLE);

  // Write 1 to clear
  assign clr_mask = wr_pending ? reg_req_i.wdata[NEXT_INT-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A new edge beats a clear in the same cycle
      pending_q <= (pending_q & ~clr_mask) | intr_i;
      if (wr_enable) begin
        enable_q <= reg_req_i.wdata[NEXT_INT-1:0];
      end
    end
  end

  assign irq_o = |(pending_q & enable_q);

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.addr)
      REG_PENDING: reg_rsp_o.rdata = DATA_W'(pending_q);
      REG_ENABLE:  reg_rsp_o.rdata = DATA_W'(enable_q);
      default:     reg_rsp_o.rdata = '0;
    endcase
  end

  irq_pending_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    irq_o |-> (|pending_q))
  else $error("intr_regs: irq raised with nothing pending");

endmodule

//--- source/reg_bus_ctrl.sv
// Register bus address decode and demux to the peripheral slots.
// Unmapped accesses get an error response with zero read data.
module reg_bus_ctrl (
  input  heep_ext_pkg::reg_req_t                          reg_req_i,
  output heep_ext_pkg::reg_rsp_t                          reg_rsp_o,
  output heep_ext_pkg::reg_req_t [heep_ext_pkg::NUM_SLOTS-1:0] slot_req_o,
  input  heep_ext_pkg::reg_rsp_t [heep_ext_pkg::NUM_SLOTS-1:0] slot_rsp_i
);
  import heep_ext_pkg::*;

  logic [NUM_SLOTS-1:0] hit;
  logic [NUM_SLOTS-1:0] slot_valid;

  // Window match per slot
  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      // Addresses below the base wrap around and fail the compare too
      hit[i] = (reg_req_i.addr - SLOT_BASE[i]) < SLOT_SPAN;
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = reg_req_i.valid & ~(|hit);
    reg_rsp_o.ready = 1'b1;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      slot_req_o[i]       = reg_req_i;
      slot_req_o[i].valid = reg_req_i.valid & hit[i];
      // Slots only see their local offset
      slot_req_o[i].addr  = reg_req_i.addr - SLOT_BASE[i];
      slot_valid[i]       = slot_req_o[i].valid;
      if (hit[i]) begin
        reg_rsp_o = slot_rsp_i[i];
      end
    end
  end

  // Overlapping windows in the address map would trip this
  always_comb begin
    one_slot_a : assert ($onehot0(slot_valid))
    else $error("reg_bus_ctrl: more than one slot selected (%b)", slot_valid);
  end

endmodule

//--- source/switch_ack_delay.sv
// Fixed-latency register chain modelling power-switch acknowledge cells.
module switch_ack_delay #(
  parameter type         payload_t = logic,
  parameter int unsigned LATENCY   = 1
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  payload_t switch_n_i,
  output payload_t switch_ack_n_o
);

  payload_t stage_q [LATENCY];

  if (LATENCY < 1) begin : gen_bad_latency
    $error("switch_ack_delay: LATENCY must be at least 1");
  end

  // Switches read as open (all ones) until the first request arrives
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < LATENCY; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = stage_q[LATENCY-1];

  // X on a request must never reach the acknowledge side
  ack_known_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(switch_ack_n_o))
  else $error("switch_ack_delay: unknown acknowledge value");

endmodule

//--- test/tb_checker.sv
// Reference model of the external subsystem and per-cycle comparisons.
// Keeps error counts per function and prints them in one closing line.
module tb_checker (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  heep_ext_pkg::reg_req_t            reg_req_i,
  input  heep_ext_pkg::reg_rsp_t            reg_rsp_i,
  input  heep_ext_pkg::pwr_switch_t         switch_n_i,
  input  heep_ext_pkg::pwr_switch_t         switch_ack_n_i,
  input  logic                              gpio_i,
  input  logic                              gpio_out_i,
  input  logic [heep_ext_pkg::NEXT_INT-2:0] intr_ext_i,
  input  logic                              irq_i,
  output int unsigned                       err_total_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import heep_ext_pkg::*;

  logic        m_en;
  logic [15:0] m_limit;
  logic [15:0] m_count;
  logic        m_gpio;
  logic        m_wrap;
  intr_vec_t   m_pend;
  intr_vec_t   m_ien;
  pwr_switch_t m_dly [SWITCH_ACK_LATENCY];
  int unsigned err_bus = 0;
  int unsigned err_pwr = 0;
  int unsigned err_cnt = 0;
  int unsigned err_irq = 0;

  assign err_total_o = err_bus + err_pwr + err_cnt + err_irq;

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act,
                           ref int unsigned cnt);
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h at %0t", name, exp, act, $time);
      cnt++;
    end
  endtask

  // Slot index from the address map, -1 when unmapped
  function automatic int slot_of(input logic [31:0] addr);
    int s;
    s = -1;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (addr >= SLOT_BASE[i] && addr < SLOT_BASE[i] + SLOT_SPAN) begin
        s = i;
      end
    end
    return s;
  endfunction

  function automatic logic [31:0] model_read(input int slot, input logic [31:0] off);
    logic [31:0] d;
    d = '0;
    if (slot == SLOT_GPIO_CNT) begin
      if (off == 32'h0) d = 32'(m_en);
      if (off == 32'h4) d = 32'(m_limit);
      if (off == 32'h8) d = 32'(m_count);
    end else if (slot == SLOT_INTR) begin
      if (off == 32'h0) d = 32'(m_pend);
      if (off == 32'h4) d = 32'(m_ien);
    end
    return d;
  endfunction

  task report();
    $display("errors: bus %0d, power switch %0d, counter %0d, interrupt %0d",
             err_bus, err_pwr, err_cnt, err_irq);
  endtask

  // Outputs are settled and inputs steady at the falling edge
  always @(negedge clk_i) begin
    int          slot;
    logic [31:0] off;
    logic        wrap_cur;

    if (!arst_n_i) begin
      m_en    = 1'b0;
      m_limit = '0;
      m_count = '0;
      m_gpio  = 1'b0;
      m_wrap  = 1'b0;
      m_pend  = '0;
      m_ien   = '0;
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        m_dly[i] = '1;
      end
    end

    slot = slot_of(reg_req_i.addr);
    off  = (slot < 0) ? 32'h0 : reg_req_i.addr - SLOT_BASE[slot];
    check_val("ready", 32'h1, 32'(reg_rsp_i.ready), err_bus);
    if (reg_req_i.valid) begin
      check_val("error", 32'(slot < 0), 32'(reg_rsp_i.error), err_bus);
      check_val("rdata", model_read(slot, off), reg_rsp_i.rdata, err_bus);
    end
    check_val("switch_ack_n_o", 32'(m_dly[SWITCH_ACK_LATENCY-1]), 32'(switch_ack_n_i), err_pwr);
    check_val("gpio_o", 32'(m_gpio), 32'(gpio_out_i), err_cnt);
    check_val("irq_o", 32'(|(m_pend & m_ien)), 32'(irq_i), err_irq);

    if (arst_n_i) begin
      wrap_cur = m_wrap;
      m_wrap   = 1'b0;
      if (m_en && gpio_i) begin
        if (m_count == m_limit) begin
          m_count = '0;
          m_gpio  = ~m_gpio;
          m_wrap  = 1'b1;
        end else begin
          m_count = m_count + 16'd1;
        end
      end
      if (reg_req_i.valid && reg_req_i.write && slot == SLOT_INTR && off == 32'h0) begin
        m_pend = m_pend & ~reg_req_i.wdata[7:0];
      end
      m_pend = m_pend | {intr_ext_i, wrap_cur};
      if (reg_req_i.valid && reg_req_i.write) begin
        if (slot == SLOT_GPIO_CNT && off == 32'h0) m_en = reg_req_i.wdata[0];
        if (slot == SLOT_GPIO_CNT && off == 32'h4) m_limit = reg_req_i.wdata[15:0];
        if (slot == SLOT_INTR && off == 32'h4) m_ien = reg_req_i.wdata[7:0];
      end
      for (int i = SWITCH_ACK_LATENCY - 1; i > 0; i--) begin
        m_dly[i] = m_dly[i-1];
      end
      m_dly[0] = switch_n_i;
    end
  end

endmodule

//--- test/tb_clk_gen.sv
// Testbench clock and reset source.
// 8 ns clock, reset held low for the first three cycles.
module tb_clk_gen #(
  parameter int unsigned RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    // Release away from the edge
    #1 arst_n_o = 1'b1;
  end

endmodule

//--- test/tb_top.sv
// Testbench top: DUT, seeded random stimulus, register bus tasks, timeout.
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;
  import heep_ext_pkg::*;

  localparam int unsigned TIMEOUT_CYCLES = 20000;

  logic                clk;
  logic                arst_n;
  reg_req_t            reg_req;
  reg_rsp_t            reg_rsp;
  pwr_switch_t         switch_n;
  pwr_switch_t         switch_ack_n;
  logic                gpio_in;
  logic                gpio_out;
  logic [NEXT_INT-2:0] intr_ext;
  logic                irq;
  int unsigned         err_total;
  int unsigned         cycles = 0;
  bit                  rand_switch = 0;
  bit                  rand_gpio = 0;
  bit                  rand_intr = 0;

  tb_clk_gen clk_gen_i (.clk_o(clk), .arst_n_o(arst_n));

  heep_ext_subsys dut_i (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .reg_req_i     (reg_req),
    .reg_rsp_o     (reg_rsp),
    .switch_n_i    (switch_n),
    .switch_ack_n_o(switch_ack_n),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out),
    .intr_ext_i    (intr_ext),
    .irq_o         (irq)
  );

  tb_checker chk_i (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .reg_req_i     (reg_req),
    .reg_rsp_i     (reg_rsp),
    .switch_n_i    (switch_n),
    .switch_ack_n_i(switch_ack_n),
    .gpio_i        (gpio_in),
    .gpio_out_i    (gpio_out),
    .intr_ext_i    (intr_ext),
    .irq_i         (irq),
    .err_total_o   (err_total)
  );

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // One bus cycle plus the side inputs enabled for the current phase
  task bus_cycle(input logic valid, input logic wr, input logic [31:0] addr,
                 input logic [31:0] wdata);
    @(posedge clk);
    #1;
    reg_req.valid = valid;
    reg_req.write = wr;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    reg_req.wstrb = 4'hf;
    if (rand_switch && $urandom_range(0, 3) == 0) switch_n = 8'($urandom());
    gpio_in  = rand_gpio ? ($urandom_range(0, 1) == 1) : 1'b0;
    intr_ext = rand_intr ? 7'($urandom() & $urandom() & $urandom()) : '0;
  endtask

  task idle_cycle();
    bus_cycle(1'b0, 1'b0, 32'h0, 32'h0);
  endtask

  // Mix of both slots, known and unknown offsets, and unmapped space
  function automatic logic [31:0] random_addr();
    logic [31:0] off;
    off = 32'($urandom_range(0, 4)) << 2;
    case ($urandom_range(0, 5))
      0, 1:    return SLOT_BASE[SLOT_GPIO_CNT] + off;
      2, 3:    return SLOT_BASE[SLOT_INTR] + off;
      4:       return 32'h2000_0200 + off;
      default: return $urandom();
    endcase
  endfunction

  initial begin
    void'($urandom(32'hd5cf_1c48));
    reg_req  = '0;
    switch_n = '1;
    gpio_in  = 1'b0;
    intr_ext = '0;
    wait (arst_n === 1'b1);
    repeat (2) idle_cycle();

    // Register accesses
    for (int i = 0; i < 1500; i++) begin
      bus_cycle($urandom_range(0, 3) != 0, $urandom_range(0, 1) == 1, random_addr(),
                $urandom());
    end
    bus_cycle(1'b1, 1'b1, SLOT_BASE[SLOT_GPIO_CNT] + REG_CTRL, 32'h0);

    // Switch requests
    rand_switch = 1;
    repeat (600) idle_cycle();
    rand_switch = 0;

    // Counter with a small limit
    bus_cycle(1'b1, 1'b1, SLOT_BASE[SLOT_INTR] + REG_ENABLE, 32'h1);
    bus_cycle(1'b1, 1'b1, SLOT_BASE[SLOT_GPIO_CNT] + REG_LIMIT, 32'($urandom_range(1, 7)));
    bus_cycle(1'b1, 1'b1, SLOT_BASE[SLOT_GPIO_CNT] + REG_CTRL, 32'h1);
    rand_gpio = 1;
    for (int i = 0; i < 1000; i++) begin
      if ($urandom_range(0, 7) == 0) begin
        bus_cycle(1'b1, 1'b0, SLOT_BASE[SLOT_GPIO_CNT] + REG_COUNT, 32'h0);
      end else if ($urandom_range(0, 15) == 0) begin
        bus_cycle(1'b1, 1'b1, SLOT_BASE[SLOT_INTR] + REG_PENDING, 32'h1);
      end else begin
        idle_cycle();
      end
    end
    rand_gpio = 0;

    // External interrupt pulses
    rand_intr = 1;
    for (int i = 0; i < 800; i++) begin
      case ($urandom_range(0, 7))
        0:       bus_cycle(1'b1, 1'b1, SLOT_BASE[SLOT_INTR] + REG_ENABLE, $urandom());
        1:       bus_cycle(1'b1, 1'b1, SLOT_BASE[SLOT_INTR] + REG_PENDING, $urandom());
        2, 3:    bus_cycle(1'b1, 1'b0, SLOT_BASE[SLOT_INTR] + REG_PENDING, 32'h0);
        default: idle_cycle();
      endcase
    end
    rand_intr = 0;
    repeat (20) idle_cycle();

    chk_i.report();
    if (err_total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
